//--- hw/insn_pkg.sv
package insn_pkg;

	//////////////////////////////
	// Opcodes
	//////////////////////////////

	// Unconditional PC-relative jump
	// 26-bit word offset, sign-extended
	localparam logic [5:0] OPC_J = 6'h00;

	// No-operation
	localparam logic [5:0] OPC_NOP = 6'h05;

	//////////////////////////////
	// NOP kinds
	//////////////////////////////

	// Flushed or suppressed fetch
	localparam logic [15:0] NOP_KIND_BYPASS = 16'h0041;

	// No valid fetch this cycle, a stall
	localparam logic [15:0] NOP_KIND_EMPTY = 16'h0061;

	//////////////////////////////
	// Instruction word views
	//////////////////////////////

	// Jump view
	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] offset;
	} insn_jump_t;

	// NOP view with a kind tag in the low half
	typedef struct packed {
		logic [5:0]  opcode;
		logic [9:0]  rsvd;
		logic [15:0] kind;
	} insn_nop_t;

	// One 32-bit word, read as a jump by the PC generator
	// and built or read as a tagged NOP by the fetch stage
	typedef union packed {
		insn_jump_t j;
		insn_nop_t  nop;
	} insn_word_u;

endpackage

//--- hw/icbus_pkg.sv
package icbus_pkg;

	//////////////////////////////
	// Response error tags
	//////////////////////////////
	localparam logic [3:0] TAG_NONE = 4'h0;
	localparam logic [3:0] TAG_TE   = 4'hD;
	localparam logic [3:0] TAG_PE   = 4'hC;
	localparam logic [3:0] TAG_BE   = 4'hB;

	//////////////////////////////
	// ROM and address windows
	//////////////////////////////

	// ROM fills the bytes below PE_BASE
	localparam int unsigned ROM_WORDS = 16;
	localparam int unsigned ROM_AW    = $clog2(ROM_WORDS);

	// Protection fault, then TLB miss, each one window wide
	// Anything beyond is a bus error
	localparam logic [31:0] PE_BASE   = 32'h0000_0040;
	localparam logic [31:0] TE_BASE   = 32'h0000_0080;
	localparam logic [31:0] WIN_BYTES = 32'd64;

	// First fetch address out of reset
	localparam logic [31:0] RESET_PC = 32'h0000_0000;

endpackage

//--- hw/pc_gen.sv
`timescale 1ns/1ps

module pc_gen (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 freeze_i,
	input  logic                 flush_i,
	input  logic [31:0]          flush_pc_i,
	input  logic                 refetch_i,
	input  insn_pkg::insn_word_u insn_i,
	input  logic [31:0]          insn_pc_i,
	output logic [31:0]          fetch_adr_o,
	output logic                 fetch_new_o
);

	logic [31:0] fetch_adr_q;
	logic [31:0] fetch_adr_d;
	logic        fetch_new_q;
	logic        jump_taken;
	logic [31:0] jump_offset;
	logic [31:0] jump_target;
	logic [31:0] refetch_adr;

	//////////////////////////////
	// Jump detection
	//////////////////////////////

	// Only a delivered and accepted jump counts
	assign jump_taken = !freeze_i && (insn_i.j.opcode == insn_pkg::OPC_J);

	// Word offset to bytes, sign-extended
	assign jump_offset = {{4{insn_i.j.offset[25]}}, insn_i.j.offset, 2'b00};
	assign jump_target = insn_pc_i + jump_offset;

	// Successor of the saved word, dropped at unfreeze
	assign refetch_adr = insn_pc_i + 32'd4;

	//////////////////////////////
	// Next fetch address
	//////////////////////////////
	always_comb begin
		if (flush_i) begin
			fetch_adr_d = flush_pc_i;
		end else if (refetch_i) begin
			fetch_adr_d = refetch_adr;
		end else if (jump_taken) begin
			// In-flight address is the delay slot
			fetch_adr_d = jump_target;
		end else if (freeze_i) begin
			fetch_adr_d = fetch_adr_q;
		end else begin
			fetch_adr_d = fetch_adr_q + 32'd4;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			fetch_adr_q <= icbus_pkg::RESET_PC;
			// Reset opens a new stream
			fetch_new_q <= 1'b1;
		end else begin
			fetch_adr_q <= fetch_adr_d;
			// Marks only the first request after a flush
			fetch_new_q <= flush_i;
		end
	end

	assign fetch_adr_o = fetch_adr_q;
	assign fetch_new_o = fetch_new_q;

	//////////////////////////////
	// Checks
	//////////////////////////////

	// Flush target is the very next request
	a_flush_target: assert property (@(posedge clk) disable iff (!rst_n_i)
		flush_i |=> (fetch_adr_o == $past(flush_pc_i)))
		else $error("pc_gen: fetch address missed flush target");

	// Frozen pipeline keeps the request steady
	a_freeze_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		(freeze_i && !flush_i && !refetch_i) |=> $stable(fetch_adr_o))
		else $error("pc_gen: fetch address moved under freeze");

endmodule

//--- hw/insn_mem_port.sv
`timescale 1ns/1ps

module insn_mem_port (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic [31:0] fetch_adr_i,
	input  logic        fetch_new_i,
	output logic [31:0] resp_dat_o,
	output logic        resp_ack_o,
	output logic        resp_err_o,
	output logic [3:0]  resp_tag_o,
	output logic [31:0] resp_adr_o,
	output logic        resp_new_o
);

	logic [31:0]                  rom [icbus_pkg::ROM_WORDS];
	logic [icbus_pkg::ROM_AW-1:0] rom_idx;
	logic                         in_rom;
	logic                         in_pe;
	logic                         in_te;
	logic [3:0]                   tag_d;

	// Instruction image
	initial begin
		$readmemh("insn_rom.hex", rom);
	end

	//////////////////////////////
	// Window decode
	//////////////////////////////
	assign rom_idx = fetch_adr_i[icbus_pkg::ROM_AW+1:2];
	assign in_rom  = fetch_adr_i < icbus_pkg::PE_BASE;
	assign in_pe   = (fetch_adr_i >= icbus_pkg::PE_BASE) &&
		(fetch_adr_i < icbus_pkg::PE_BASE + icbus_pkg::WIN_BYTES);
	assign in_te   = (fetch_adr_i >= icbus_pkg::TE_BASE) &&
		(fetch_adr_i < icbus_pkg::TE_BASE + icbus_pkg::WIN_BYTES);

	// Protection window first, then TLB, else bus error
	always_comb begin
		if (in_rom) begin
			tag_d = icbus_pkg::TAG_NONE;
		end else if (in_pe) begin
			tag_d = icbus_pkg::TAG_PE;
		end else if (in_te) begin
			tag_d = icbus_pkg::TAG_TE;
		end else begin
			tag_d = icbus_pkg::TAG_BE;
		end
	end

	//////////////////////////////
	// One-cycle response
	//////////////////////////////
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			resp_ack_o <= 1'b0;
			resp_err_o <= 1'b0;
			resp_tag_o <= icbus_pkg::TAG_NONE;
			resp_new_o <= 1'b0;
		end else begin
			resp_ack_o <= in_rom;
			resp_err_o <= !in_rom;
			resp_tag_o <= tag_d;
			resp_new_o <= fetch_new_i;
		end
	end

	// Data and echoed word address
	always_ff @(posedge clk) begin
		resp_dat_o <= in_rom ? rom[rom_idx] : 32'h0;
		resp_adr_o <= {fetch_adr_i[31:2], 2'b00};
	end

	// Once out of reset, one answer per cycle
	a_one_response: assert property (@(posedge clk) disable iff (!rst_n_i)
		$past(rst_n_i) |-> $onehot({resp_ack_o, resp_err_o}))
		else $error("insn_mem_port: ack and err not exclusive");

endmodule

//--- hw/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic [31:0]          resp_dat_i,
	input  logic                 resp_ack_i,
	input  logic                 resp_err_i,
	input  logic [3:0]           resp_tag_i,
	input  logic [31:0]          resp_adr_i,
	input  logic                 resp_new_i,
	input  logic                 freeze_i,
	input  logic                 flush_i,
	input  logic                 no_more_dslot_i,
	input  logic                 rfe_i,
	output insn_pkg::insn_word_u insn_o,
	output logic [31:0]          pc_o,
	output logic                 stall_o,
	output logic                 saving_insn_o,
	output logic                 refetch_o,
	output logic                 except_itlbmiss_o,
	output logic                 except_immufault_o,
	output logic                 except_ibuserr_o
);

	insn_pkg::insn_word_u nop_bypass;
	insn_pkg::insn_word_u nop_empty;
	insn_pkg::insn_word_u insn_saved_q;
	logic [31:0]          addr_saved_q;
	logic [2:0]           err_saved_q;
	logic [2:0]           err_live;
	logic [31:0]          resp_adr_w;
	logic                 saved_q;
	logic                 bypass_q;
	logic                 bypass;
	logic                 refetch_q;
	logic                 resp_vld;
	logic                 save_insn;
	logic                 kill_exc;

	// Tagged NOPs through the NOP view
	always_comb begin
		nop_bypass          = '0;
		nop_bypass.nop.opcode = insn_pkg::OPC_NOP;
		nop_bypass.nop.kind   = insn_pkg::NOP_KIND_BYPASS;
		nop_empty           = '0;
		nop_empty.nop.opcode  = insn_pkg::OPC_NOP;
		nop_empty.nop.kind    = insn_pkg::NOP_KIND_EMPTY;
	end

	//////////////////////////////
	// Response qualification
	//////////////////////////////
	assign resp_adr_w = {resp_adr_i[31:2], 2'b00};
	// Response right after a refetch is stale
	assign resp_vld   = (resp_ack_i || resp_err_i) && !refetch_q;
	assign save_insn  = resp_vld && freeze_i && !saved_q;
	assign saving_insn_o = save_insn && !flush_i;

	// Error tag to TLB miss, MMU fault, bus error
	assign err_live[0] = resp_err_i && (resp_tag_i == icbus_pkg::TAG_TE);
	assign err_live[1] = resp_err_i && (resp_tag_i == icbus_pkg::TAG_PE);
	assign err_live[2] = resp_err_i && (resp_tag_i == icbus_pkg::TAG_BE);

	// Held until the flushed stream's first answer
	assign bypass = flush_i || (bypass_q && !resp_new_i);

	// Unfreeze drops the in-flight successor of a saved non-jump
	assign refetch_o = saved_q && resp_vld && !freeze_i &&
		(resp_adr_w == addr_saved_q + 32'd4) &&
		(insn_saved_q.j.opcode != insn_pkg::OPC_J);

	//////////////////////////////
	// Delivered word
	//////////////////////////////
	always_comb begin
		if (no_more_dslot_i || rfe_i || bypass) begin
			insn_o = nop_bypass;
		end else if (saved_q) begin
			insn_o = insn_saved_q;
		end else if (resp_ack_i && !refetch_q) begin
			insn_o = resp_dat_i;
		end else begin
			insn_o = nop_empty;
		end
	end

	assign pc_o    = saved_q ? addr_saved_q : resp_adr_w;
	assign stall_o = !resp_vld && !saved_q;

	assign kill_exc = no_more_dslot_i || rfe_i || bypass || refetch_q;
	assign except_itlbmiss_o  = !kill_exc && (saved_q ? err_saved_q[0] : err_live[0]);
	assign except_immufault_o = !kill_exc && (saved_q ? err_saved_q[1] : err_live[1]);
	assign except_ibuserr_o   = !kill_exc && (saved_q ? err_saved_q[2] : err_live[2]);

	//////////////////////////////
	// Save state
	//////////////////////////////

	// Flush first, then save, then unfreeze
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			saved_q      <= 1'b0;
			addr_saved_q <= 32'h0;
			bypass_q     <= 1'b0;
			refetch_q    <= 1'b0;
		end else begin
			bypass_q  <= bypass;
			refetch_q <= refetch_o && !flush_i;
			if (flush_i) begin
				saved_q      <= 1'b0;
				addr_saved_q <= 32'h0;
			end else if (save_insn) begin
				saved_q      <= 1'b1;
				addr_saved_q <= resp_adr_w;
			end else if (!freeze_i) begin
				saved_q      <= 1'b0;
				addr_saved_q <= resp_adr_w;
			end
		end
	end

	// Saved word and its fault bits
	always_ff @(posedge clk) begin
		if (flush_i || (!save_insn && !freeze_i)) begin
			insn_saved_q <= nop_bypass;
			err_saved_q  <= 3'b000;
		end else if (save_insn) begin
			insn_saved_q <= resp_err_i ? nop_bypass : resp_dat_i;
			err_saved_q  <= err_live;
		end
	end

	// Suppressed slot never raises a fault
	a_no_exc_in_dslot: assert property (@(posedge clk) disable iff (!rst_n_i)
		no_more_dslot_i |-> !(except_itlbmiss_o || except_immufault_o || except_ibuserr_o))
		else $error("fetch_stage: exception raised with no_more_dslot");

	a_save_sets_flag: assert property (@(posedge clk) disable iff (!rst_n_i)
		(save_insn && !flush_i) |=> saved_q)
		else $error("fetch_stage: saved flag missing after save");

	a_flush_clears_addr: assert property (@(posedge clk) disable iff (!rst_n_i)
		flush_i |=> (addr_saved_q == 32'h0))
		else $error("fetch_stage: saved address not cleared by flush");

endmodule

//--- hw/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic        freeze_i,
	input  logic        flush_i,
	input  logic [31:0] flush_pc_i,
	input  logic        no_more_dslot_i,
	input  logic        rfe_i,
	output logic [31:0] insn_o,
	output logic [31:0] pc_o,
	output logic        stall_o,
	output logic        saving_insn_o,
	output logic        except_itlbmiss_o,
	output logic        except_immufault_o,
	output logic        except_ibuserr_o
);

	// Request side
	logic [31:0] fetch_adr;
	logic        fetch_new;

	// Response side
	logic [31:0] resp_dat;
	logic        resp_ack;
	logic        resp_err;
	logic [3:0]  resp_tag;
	logic [31:0] resp_adr;
	logic        resp_new;

	// Lost successor after unfreeze
	logic        refetch;

	//////////////////////////////
	// Address generation
	//////////////////////////////

	// Jumps seen on the delivered word and pc
	pc_gen pc_gen_i (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.freeze_i    (freeze_i),
		.flush_i     (flush_i),
		.flush_pc_i  (flush_pc_i),
		.refetch_i   (refetch),
		.insn_i      (insn_o),
		.insn_pc_i   (pc_o),
		.fetch_adr_o (fetch_adr),
		.fetch_new_o (fetch_new)
	);

	//////////////////////////////
	// Cache model
	//////////////////////////////
	insn_mem_port insn_mem_port_i (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.fetch_adr_i (fetch_adr),
		.fetch_new_i (fetch_new),
		.resp_dat_o  (resp_dat),
		.resp_ack_o  (resp_ack),
		.resp_err_o  (resp_err),
		.resp_tag_o  (resp_tag),
		.resp_adr_o  (resp_adr),
		.resp_new_o  (resp_new)
	);

	//////////////////////////////
	// Fetch stage
	//////////////////////////////
	fetch_stage fetch_stage_i (
		.clk                (clk),
		.rst_n_i            (rst_n_i),
		.resp_dat_i         (resp_dat),
		.resp_ack_i         (resp_ack),
		.resp_err_i         (resp_err),
		.resp_tag_i         (resp_tag),
		.resp_adr_i         (resp_adr),
		.resp_new_i         (resp_new),
		.freeze_i           (freeze_i),
		.flush_i            (flush_i),
		.no_more_dslot_i    (no_more_dslot_i),
		.rfe_i              (rfe_i),
		.insn_o             (insn_o),
		.pc_o               (pc_o),
		.stall_o            (stall_o),
		.saving_insn_o      (saving_insn_o),
		.refetch_o          (refetch),
		.except_itlbmiss_o  (except_itlbmiss_o),
		.except_immufault_o (except_immufault_o),
		.except_ibuserr_o   (except_ibuserr_o)
	);

endmodule

//--- tests/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

	logic        clk;
	logic        rst_n;
	logic        freeze;
	logic        flush;
	logic [31:0] flush_pc;
	logic        no_more_dslot;
	logic        rfe;
	logic [31:0] insn;
	logic [31:0] pc;
	logic        stall;
	logic        saving_insn;
	logic        exc_itlb;
	logic        exc_immu;
	logic        exc_ibus;

	// Reference image and model state
	logic [31:0] rom_ref [16];
	logic [31:0] exp_pc;
	logic        tracking;
	logic        jmp_pend;
	logic        tgt_next;
	logic [31:0] jmp_tgt;
	int unsigned acc_cnt;
	logic [1:0]  flush_age;
	logic [31:0] flush_tgt;
	int unsigned frz_age;
	logic [31:0] frz_pc;
	logic [31:0] frz_insn;
	logic [15:0] lfsr_q;
	int unsigned err_cnt;
	logic        timed_out;
	logic [31:0] draw;
	logic        accept;
	logic        check_flags;
	logic [31:0] bypass_nop;

	fetch_top fetch_top_i (
		.clk                (clk),
		.rst_n_i            (rst_n),
		.freeze_i           (freeze),
		.flush_i            (flush),
		.flush_pc_i         (flush_pc),
		.no_more_dslot_i    (no_more_dslot),
		.rfe_i              (rfe),
		.insn_o             (insn),
		.pc_o               (pc),
		.stall_o            (stall),
		.saving_insn_o      (saving_insn),
		.except_itlbmiss_o  (exc_itlb),
		.except_immufault_o (exc_immu),
		.except_ibuserr_o   (exc_ibus)
	);

	initial begin
		clk = 1'b0;
	end

	// 4 ns period
	always begin
		#2 clk = ~clk;
	end

	initial begin
		$readmemh("insn_rom.hex", rom_ref);
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// Fault window of a byte address as {bus, mmu, tlb}
	function automatic logic [2:0] window_flags(input logic [31:0] adr);
		if (adr < icbus_pkg::PE_BASE) begin
			return 3'b000;
		end else if (adr < icbus_pkg::PE_BASE + icbus_pkg::WIN_BYTES) begin
			return 3'b010;
		end else if (adr < icbus_pkg::TE_BASE + icbus_pkg::WIN_BYTES) begin
			return 3'b001;
		end
		return 3'b100;
	endfunction

	// Jump destination, low 26 bits are a two's complement word count
	function automatic logic [31:0] jump_dest(input logic [31:0] at, input logic [31:0] word);
		int words;
		words = int'(word[25:0]);
		if (word[25]) begin
			words = words - (1 << 26);
		end
		return at + 32'(words * 4);
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
	endtask

	task automatic cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	// Accepted deliveries, counted by the model
	task automatic wait_accepts(input int n);
		int unsigned target;
		int          guard;
		target = acc_cnt + n;
		guard = 0;
		while (!timed_out && acc_cnt < target) begin
			@(posedge clk);
			#1;
			guard++;
			if (guard > 200) begin
				$display("timeout while waiting for %0d accepted instructions", n);
				timed_out = 1'b1;
			end
		end
	endtask

	// A valid non-NOP word on the output right now
	task automatic wait_ready();
		int guard;
		guard = 0;
		while (!timed_out && (stall || insn[31:26] == insn_pkg::OPC_NOP)) begin
			@(posedge clk);
			#1;
			guard++;
			if (guard > 50) begin
				$display("timeout while waiting for a valid instruction");
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic pulse_flush(input logic [31:0] target);
		flush_pc = target;
		flush    = 1'b1;
		cycles(1);
		flush    = 1'b0;
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////
	assign bypass_nop = {insn_pkg::OPC_NOP, 10'h000, insn_pkg::NOP_KIND_BYPASS};
	assign accept = rst_n && !freeze && !stall && insn[31:26] != insn_pkg::OPC_NOP;
	assign check_flags = rst_n && !stall && !freeze && !no_more_dslot && !rfe &&
		!flush && flush_age != 2'd1;

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exp_pc   <= icbus_pkg::RESET_PC;
			tracking <= 1'b1;
			jmp_pend <= 1'b0;
			tgt_next <= 1'b0;
			jmp_tgt  <= '0;
			acc_cnt  <= 0;
		end else if (flush) begin
			// New stream, model restarts at the target
			exp_pc   <= flush_pc;
			tracking <= flush_pc < icbus_pkg::PE_BASE;
			jmp_pend <= 1'b0;
			tgt_next <= 1'b0;
		end else if (no_more_dslot || rfe) begin
			tracking <= 1'b0;
		end else if (accept) begin
			acc_cnt  <= acc_cnt + 1;
			tgt_next <= jmp_pend;
			if (jmp_pend) begin
				exp_pc   <= jmp_tgt;
				jmp_pend <= 1'b0;
			end else begin
				exp_pc <= exp_pc + 32'd4;
			end
			// Jump seen in the reference image at the expected address
			if (rom_ref[exp_pc[5:2]][31:26] == insn_pkg::OPC_J) begin
				jmp_pend <= 1'b1;
				jmp_tgt  <= jump_dest(exp_pc, rom_ref[exp_pc[5:2]]);
			end
		end
	end

	// Cycles since a flush, and freeze episode capture
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flush_age <= 2'd0;
			flush_tgt <= '0;
			frz_age   <= 0;
			frz_pc    <= '0;
			frz_insn  <= '0;
		end else begin
			if (flush) begin
				flush_age <= 2'd1;
				flush_tgt <= flush_pc;
			end else if (flush_age == 2'd1) begin
				flush_age <= 2'd2;
			end else begin
				flush_age <= 2'd0;
			end
			if (freeze) begin
				if (frz_age == 0) begin
					frz_pc   <= pc;
					frz_insn <= insn;
				end
				frz_age <= frz_age + 1;
			end else begin
				frz_age <= 0;
			end
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	// No response is valid yet in the first cycle out of reset
	a_reset_stall: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(rst_n) |-> stall)
		else begin
			err_cnt++;
			$display("error reset_stall expected 1 actual %b", $sampled(stall));
		end

	a_rom_word: assert property (@(posedge clk) disable iff (!rst_n)
		(accept && tracking) |-> (pc < 32'h40 && insn == rom_ref[pc[5:2]]))
		else begin
			err_cnt++;
			$display("error rom_word expected %h actual %h",
				rom_ref[$sampled(pc[5:2])], $sampled(insn));
		end

	a_seq_pc: assert property (@(posedge clk) disable iff (!rst_n)
		(accept && tracking && !jmp_pend && !tgt_next) |-> pc == exp_pc)
		else begin
			err_cnt++;
			$display("error sequential expected %h actual %h", $sampled(exp_pc), $sampled(pc));
		end

	a_dslot_pc: assert property (@(posedge clk) disable iff (!rst_n)
		(accept && tracking && jmp_pend) |-> pc == exp_pc)
		else begin
			err_cnt++;
			$display("error delay_slot expected %h actual %h", $sampled(exp_pc), $sampled(pc));
		end

	a_target_pc: assert property (@(posedge clk) disable iff (!rst_n)
		(accept && tracking && tgt_next) |-> pc == exp_pc)
		else begin
			err_cnt++;
			$display("error jump_target expected %h actual %h", $sampled(exp_pc), $sampled(pc));
		end

	// Saved word shown for the whole freeze
	a_freeze_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(freeze && frz_age != 0) |-> (pc == frz_pc && insn == frz_insn))
		else begin
			err_cnt++;
			$display("error freeze_hold expected %h %h actual %h %h",
				$sampled(frz_pc), $sampled(frz_insn), $sampled(pc), $sampled(insn));
		end

	a_save_first: assert property (@(posedge clk) disable iff (!rst_n)
		(freeze && frz_age == 0) |-> saving_insn)
		else begin
			err_cnt++;
			$display("error save_pulse expected 1 actual %b", $sampled(saving_insn));
		end

	a_save_once: assert property (@(posedge clk) disable iff (!rst_n)
		(freeze && frz_age != 0) |-> !saving_insn)
		else begin
			err_cnt++;
			$display("error save_once expected 0 actual %b", $sampled(saving_insn));
		end

	a_flush_bypass: assert property (@(posedge clk) disable iff (!rst_n)
		(flush_age == 2'd1) |-> insn == bypass_nop)
		else begin
			err_cnt++;
			$display("error flush_bypass expected %h actual %h",
				$sampled(bypass_nop), $sampled(insn));
		end

	a_flush_pc: assert property (@(posedge clk) disable iff (!rst_n)
		(flush_age == 2'd2) |-> pc == flush_tgt)
		else begin
			err_cnt++;
			$display("error flush_pc expected %h actual %h", $sampled(flush_tgt), $sampled(pc));
		end

	a_fault_flags: assert property (@(posedge clk) disable iff (!rst_n)
		check_flags |-> {exc_ibus, exc_immu, exc_itlb} == window_flags(pc))
		else begin
			err_cnt++;
			$display("error fault_flags expected %b actual %b",
				window_flags($sampled(pc)), $sampled({exc_ibus, exc_immu, exc_itlb}));
		end

	a_suppress: assert property (@(posedge clk) disable iff (!rst_n)
		(no_more_dslot || rfe) |-> ({exc_ibus, exc_immu, exc_itlb} == 3'b000 &&
			insn == bypass_nop))
		else begin
			err_cnt++;
			$display("error suppress expected %b %h actual %b %h",
				3'b000, $sampled(bypass_nop),
				$sampled({exc_ibus, exc_immu, exc_itlb}), $sampled(insn));
		end

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	initial begin
		rst_n         = 1'b0;
		freeze        = 1'b0;
		flush         = 1'b0;
		flush_pc      = '0;
		no_more_dslot = 1'b0;
		rfe           = 1'b0;
		lfsr_q        = 16'd18;
		err_cnt       = 0;
		timed_out     = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Straight fetch through both jumps, several laps
		wait_accepts(40);

		// Freezes of 1 to 8 cycles
		for (int i = 0; i < 6; i++) begin
			wait_accepts(3);
			wait_ready();
			draw_bits(3, draw);
			freeze = 1'b1;
			cycles(draw + 1);
			freeze = 1'b0;
			wait_accepts(4);
		end

		// Redirects inside the ROM
		for (int i = 0; i < 4; i++) begin
			draw_bits(3, draw);
			pulse_flush({draw[28:0], 2'b00});
			wait_accepts(6);
		end

		// Protection, TLB and bus error windows
		draw_bits(4, draw);
		pulse_flush(icbus_pkg::PE_BASE + {draw[29:0], 2'b00});
		cycles(4);
		draw_bits(4, draw);
		pulse_flush(icbus_pkg::TE_BASE + {draw[29:0], 2'b00});
		cycles(4);
		draw_bits(4, draw);
		pulse_flush(32'h0000_0100 + {draw[29:0], 2'b00});
		cycles(4);

		// Suppressed slots on a faulting stream
		no_more_dslot = 1'b1;
		cycles(3);
		no_more_dslot = 1'b0;
		rfe = 1'b1;
		cycles(3);
		rfe = 1'b0;
		cycles(2);

		// Back to the ROM, then suppression on good words
		pulse_flush(32'h0);
		wait_accepts(12);
		no_more_dslot = 1'b1;
		cycles(2);
		no_more_dslot = 1'b0;
		pulse_flush(32'h10);
		wait_accepts(8);
		cycles(2);

		$display("checks done: %0d errors, timeout %0d", err_cnt, timed_out);
		if (err_cnt == 0 && !timed_out) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- list.f
hw/insn_pkg.sv
hw/icbus_pkg.sv
hw/pc_gen.sv
hw/insn_mem_port.sv
hw/fetch_stage.sv
hw/fetch_top.sv
tests/fetch_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module fetch_tb -f list.f \
	--Mdir obj_dir -o fetch_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/fetch_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
	exit 1
fi

if ! grep -q "TESTBENCH PASSED" sim.log; then
	echo "Simulation ended without a result line"
	exit 1
fi

exit 0

//--- insn_rom.hex
// One 32-bit instruction word per line, word address 0 to 15
20000100
20000101
20000102
20000103
20000104
00000003
20000106
20000107
20000108
20000109
2000010A
2000010B
2000010C
2000010D
03FFFFF2
2000010F
